// File: logic/mmu_defs.svh
//--------------------------------------------------------------------
// MMU widths, TLB size and encodings
//--------------------------------------------------------------------
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// Sv32 address geometry
`define MMU_VLEN    32
`define MMU_PLEN    34
`define MMU_PPNW    22
`define MMU_VPNW    20
`define MMU_ASIDW   9
`define MMU_OFFW    12
`define MMU_MEGA_LO 10

`define DTLB_ENTRIES 4

// flag byte of a PTE
`define PTE_V 0
`define PTE_R 1
`define PTE_W 2
`define PTE_X 3
`define PTE_U 4
`define PTE_G 5
`define PTE_A 6
`define PTE_D 7

`define PRIV_U 0
`define PRIV_S 1

// exception causes, privileged spec numbering
`define CAUSE_LD_MISALIGNED 4
`define CAUSE_ST_MISALIGNED 6
`define CAUSE_LD_PAGE_FAULT 13
`define CAUSE_ST_PAGE_FAULT 15

`endif

// File: logic/mmu_pkg.sv
//--------------------------------------------------------------------
// MMU shared types
//--------------------------------------------------------------------
`include "mmu_defs.svh"

package mmu_pkg;

  // addresses
  typedef logic [`MMU_VLEN-1:0] vaddr_t;
  typedef logic [`MMU_PLEN-1:0] paddr_t;

  // page numbers
  typedef logic [`MMU_PPNW-1:0] ppn_t;
  typedef logic [`MMU_VPNW-1:0] vpn_t;

  typedef logic [`MMU_ASIDW-1:0] asid_t;

  // V R W X U G A D, bit 0 first
  typedef logic [7:0] pte_flags_t;

  typedef logic [1:0] priv_t;

  // low bits of mcause/scause
  typedef logic [3:0] exc_cause_t;

endpackage

// File: logic/lsu_req_decode.sv
//--------------------------------------------------------------------
// LSU request decode and pipeline register
//--------------------------------------------------------------------
`include "mmu_defs.svh"

module lsu_req_decode (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 en_ld_st_translation_i,
  input  logic                 lsu_req_i,
  input  mmu_pkg::vaddr_t      lsu_vaddr_i,
  input  logic                 lsu_is_store_i,
  input  logic                 misaligned_i,
  input  mmu_pkg::priv_t       ld_st_priv_lvl_i,
  input  logic                 sum_i,
  input  logic                 lu_hit_i,
  input  mmu_pkg::ppn_t        lu_ppn_i,
  input  mmu_pkg::pte_flags_t  lu_flags_i,
  input  logic                 lu_is_mega_i,
  output logic                 lu_access_o,
  output logic                 lsu_dtlb_hit_o,
  output mmu_pkg::ppn_t        lsu_dtlb_ppn_o,
  output logic                 dtlb_miss_o,
  output logic                 req_q_o,
  output mmu_pkg::vaddr_t      vaddr_q_o,
  output logic                 is_store_q_o,
  output logic                 misaligned_q_o,
  output logic                 translate_q_o,
  output logic                 hit_q_o,
  output mmu_pkg::ppn_t        ppn_q_o,
  output mmu_pkg::pte_flags_t  flags_q_o,
  output logic                 mega_q_o,
  output mmu_pkg::priv_t       priv_q_o,
  output logic                 sum_q_o
);

  // misaligned requests never look up the TLB
  assign lu_access_o    = lsu_req_i & ~misaligned_i;
  assign lsu_dtlb_hit_o = en_ld_st_translation_i ? lu_hit_i : 1'b1;
  assign dtlb_miss_o    = en_ld_st_translation_i & lu_access_o & ~lu_hit_i;

  // early PPN, megapage low bits come from the vaddr
  always_comb begin
    if (en_ld_st_translation_i) begin
      lsu_dtlb_ppn_o = lu_ppn_i;
      if (lu_is_mega_i) begin
        lsu_dtlb_ppn_o[`MMU_MEGA_LO-1:0] = lsu_vaddr_i[`MMU_OFFW +: `MMU_MEGA_LO];
      end
    end else begin
      lsu_dtlb_ppn_o = {{(`MMU_PLEN-`MMU_VLEN){1'b0}}, lsu_vaddr_i[`MMU_VLEN-1:`MMU_OFFW]};
    end
  end

  //--------------------------------------------------------------------
  // request register
  //--------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q_o        <= 1'b0;
      misaligned_q_o <= 1'b0;
      translate_q_o  <= 1'b0;
      hit_q_o        <= 1'b0;
    end else begin
      req_q_o        <= lsu_req_i;
      // mute a stray misaligned flag with no request behind it
      misaligned_q_o <= misaligned_i & lsu_req_i;
      translate_q_o  <= en_ld_st_translation_i;
      hit_q_o        <= lu_hit_i;
    end
  end

  // payload captured alongside the request
  always_ff @(posedge clk_i) begin
    vaddr_q_o    <= lsu_vaddr_i;
    is_store_q_o <= lsu_is_store_i;
    ppn_q_o      <= lu_ppn_i;
    flags_q_o    <= lu_flags_i;
    mega_q_o     <= lu_is_mega_i;
    priv_q_o     <= ld_st_priv_lvl_i;
    sum_q_o      <= sum_i;
  end

endmodule

// File: logic/dtlb_execute.sv
//--------------------------------------------------------------------
// Fully associative data TLB
//--------------------------------------------------------------------
`include "mmu_defs.svh"

module dtlb_execute (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 lu_access_i,
  input  mmu_pkg::vaddr_t      lu_vaddr_i,
  input  mmu_pkg::asid_t       lu_asid_i,
  input  logic                 flush_i,
  input  logic                 update_valid_i,
  input  mmu_pkg::vpn_t        update_vpn_i,
  input  mmu_pkg::asid_t       update_asid_i,
  input  mmu_pkg::ppn_t        update_ppn_i,
  input  mmu_pkg::pte_flags_t  update_flags_i,
  input  logic                 update_is_mega_i,
  output logic                 lu_hit_o,
  output mmu_pkg::ppn_t        lu_ppn_o,
  output mmu_pkg::pte_flags_t  lu_flags_o,
  output logic                 lu_is_mega_o
);

  localparam int IdxW = (`DTLB_ENTRIES > 1) ? $clog2(`DTLB_ENTRIES) : 1;
  localparam int HiW  = `MMU_VPNW - `MMU_MEGA_LO;

  // tag and content per entry, V flag doubles as the entry valid
  mmu_pkg::vpn_t       tag_vpn   [`DTLB_ENTRIES];
  mmu_pkg::asid_t      tag_asid  [`DTLB_ENTRIES];
  logic                tag_mega  [`DTLB_ENTRIES];
  mmu_pkg::ppn_t       ent_ppn   [`DTLB_ENTRIES];
  mmu_pkg::pte_flags_t ent_flags [`DTLB_ENTRIES];

  logic [IdxW-1:0]          repl_ptr_q;
  logic [`DTLB_ENTRIES-1:0] match;
  mmu_pkg::vpn_t            lu_vpn;

  assign lu_vpn = lu_vaddr_i[`MMU_VLEN-1:`MMU_OFFW];

  //--------------------------------------------------------------------
  // lookup
  //--------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `DTLB_ENTRIES; i++) begin
      match[i] = ent_flags[i][`PTE_V]
                 && (tag_asid[i] == lu_asid_i || ent_flags[i][`PTE_G])
                 && (tag_vpn[i][`MMU_VPNW-1 -: HiW] == lu_vpn[`MMU_VPNW-1 -: HiW])
                 && (tag_mega[i]
                     || tag_vpn[i][`MMU_MEGA_LO-1:0] == lu_vpn[`MMU_MEGA_LO-1:0]);
    end
  end

  // lowest matching entry wins, refill keeps entries unique anyway
  always_comb begin
    lu_hit_o     = 1'b0;
    lu_ppn_o     = '0;
    lu_flags_o   = '0;
    lu_is_mega_o = 1'b0;
    for (int i = `DTLB_ENTRIES - 1; i >= 0; i--) begin
      if (lu_access_i && match[i]) begin
        lu_hit_o     = 1'b1;
        lu_ppn_o     = ent_ppn[i];
        lu_flags_o   = ent_flags[i];
        lu_is_mega_o = tag_mega[i];
      end
    end
  end

  //--------------------------------------------------------------------
  // refill, replacement and flush
  //--------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      repl_ptr_q <= '0;
      for (int i = 0; i < `DTLB_ENTRIES; i++) begin
        tag_vpn[i]   <= '0;
        tag_asid[i]  <= '0;
        tag_mega[i]  <= 1'b0;
        ent_ppn[i]   <= '0;
        ent_flags[i] <= '0;
      end
    end else if (flush_i) begin
      // flush beats a refill in the same cycle
      for (int i = 0; i < `DTLB_ENTRIES; i++) begin
        ent_flags[i][`PTE_V] <= 1'b0;
      end
    end else if (update_valid_i) begin
      tag_vpn[repl_ptr_q]   <= update_vpn_i;
      tag_asid[repl_ptr_q]  <= update_asid_i;
      tag_mega[repl_ptr_q]  <= update_is_mega_i;
      ent_ppn[repl_ptr_q]   <= update_ppn_i;
      ent_flags[repl_ptr_q] <= update_flags_i;
      if (repl_ptr_q == IdxW'(`DTLB_ENTRIES - 1)) begin
        repl_ptr_q <= '0;
      end else begin
        repl_ptr_q <= repl_ptr_q + 1'b1;
      end
    end
  end

endmodule

// File: logic/translation_result.sv
//--------------------------------------------------------------------
// Translation result and fault check
//--------------------------------------------------------------------
`include "mmu_defs.svh"

module translation_result (
  input  logic                 req_q_i,
  input  mmu_pkg::vaddr_t      vaddr_q_i,
  input  logic                 is_store_q_i,
  input  logic                 misaligned_q_i,
  input  logic                 translate_q_i,
  input  logic                 hit_q_i,
  input  mmu_pkg::ppn_t        ppn_q_i,
  input  mmu_pkg::pte_flags_t  flags_q_i,
  input  logic                 mega_q_i,
  input  mmu_pkg::priv_t       priv_q_i,
  input  logic                 sum_q_i,
  output logic                 lsu_valid_o,
  output mmu_pkg::paddr_t      lsu_paddr_o,
  output logic                 lsu_ex_valid_o,
  output mmu_pkg::exc_cause_t  lsu_ex_cause_o,
  output mmu_pkg::vaddr_t      lsu_ex_tval_o
);

  mmu_pkg::ppn_t ppn;
  logic          priv_err;
  logic          store_err;
  logic          page_fault;

  //--------------------------------------------------------------------
  // physical address
  //--------------------------------------------------------------------
  always_comb begin
    ppn = ppn_q_i;
    // megapage keeps VPN[0] of the vaddr
    if (mega_q_i) begin
      ppn[`MMU_MEGA_LO-1:0] = vaddr_q_i[`MMU_OFFW +: `MMU_MEGA_LO];
    end
  end

  assign lsu_paddr_o = translate_q_i
                       ? {ppn, vaddr_q_i[`MMU_OFFW-1:0]}
                       : {{(`MMU_PLEN-`MMU_VLEN){1'b0}}, vaddr_q_i};

  // a miss under translation gives no valid, the requester retries
  assign lsu_valid_o = req_q_i & (~translate_q_i | misaligned_q_i | hit_q_i);

  //--------------------------------------------------------------------
  // permission checks
  //--------------------------------------------------------------------
  // user page from S mode needs SUM, U mode needs a user page
  assign priv_err =
    (priv_q_i == mmu_pkg::priv_t'(`PRIV_U) && !flags_q_i[`PTE_U])
    || (priv_q_i == mmu_pkg::priv_t'(`PRIV_S) && flags_q_i[`PTE_U] && !sum_q_i);

  // stores also need a writable and dirty page
  assign store_err = is_store_q_i & (~flags_q_i[`PTE_W] | ~flags_q_i[`PTE_D]);

  assign page_fault = req_q_i & translate_q_i & hit_q_i & (priv_err | store_err);

  // misaligned first, page check only after it
  always_comb begin
    lsu_ex_valid_o = 1'b0;
    lsu_ex_cause_o = '0;
    if (misaligned_q_i) begin
      lsu_ex_valid_o = 1'b1;
      lsu_ex_cause_o = is_store_q_i ? mmu_pkg::exc_cause_t'(`CAUSE_ST_MISALIGNED)
                                    : mmu_pkg::exc_cause_t'(`CAUSE_LD_MISALIGNED);
    end else if (page_fault) begin
      lsu_ex_valid_o = 1'b1;
      lsu_ex_cause_o = is_store_q_i ? mmu_pkg::exc_cause_t'(`CAUSE_ST_PAGE_FAULT)
                                    : mmu_pkg::exc_cause_t'(`CAUSE_LD_PAGE_FAULT);
    end
  end

  assign lsu_ex_tval_o = lsu_ex_valid_o ? vaddr_q_i : '0;

endmodule

// File: logic/mmu_top.sv
//--------------------------------------------------------------------
// Data-side Sv32 MMU
//--------------------------------------------------------------------
module mmu_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 en_ld_st_translation_i,
  input  mmu_pkg::priv_t       ld_st_priv_lvl_i,
  input  logic                 sum_i,
  input  mmu_pkg::asid_t       asid_i,
  input  logic                 lsu_req_i,
  input  mmu_pkg::vaddr_t      lsu_vaddr_i,
  input  logic                 lsu_is_store_i,
  input  logic                 misaligned_i,
  input  logic                 update_valid_i,
  input  mmu_pkg::vpn_t        update_vpn_i,
  input  mmu_pkg::asid_t       update_asid_i,
  input  mmu_pkg::ppn_t        update_ppn_i,
  input  mmu_pkg::pte_flags_t  update_flags_i,
  input  logic                 update_is_mega_i,
  input  logic                 flush_tlb_i,
  output logic                 lsu_dtlb_hit_o,
  output mmu_pkg::ppn_t        lsu_dtlb_ppn_o,
  output logic                 lsu_valid_o,
  output mmu_pkg::paddr_t      lsu_paddr_o,
  output logic                 lsu_ex_valid_o,
  output mmu_pkg::exc_cause_t  lsu_ex_cause_o,
  output mmu_pkg::vaddr_t      lsu_ex_tval_o,
  output logic                 dtlb_miss_o
);

  // lookup path
  logic                lu_access;
  logic                lu_hit;
  mmu_pkg::ppn_t       lu_ppn;
  mmu_pkg::pte_flags_t lu_flags;
  logic                lu_is_mega;

  // registered request
  logic                req_q;
  mmu_pkg::vaddr_t     vaddr_q;
  logic                is_store_q;
  logic                misaligned_q;
  logic                translate_q;
  logic                hit_q;
  mmu_pkg::ppn_t       ppn_q;
  mmu_pkg::pte_flags_t flags_q;
  logic                mega_q;
  mmu_pkg::priv_t      priv_q;
  logic                sum_q;

  lsu_req_decode u_decode (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .lsu_req_i              (lsu_req_i),
    .lsu_vaddr_i            (lsu_vaddr_i),
    .lsu_is_store_i         (lsu_is_store_i),
    .misaligned_i           (misaligned_i),
    .ld_st_priv_lvl_i       (ld_st_priv_lvl_i),
    .sum_i                  (sum_i),
    .lu_hit_i               (lu_hit),
    .lu_ppn_i               (lu_ppn),
    .lu_flags_i             (lu_flags),
    .lu_is_mega_i           (lu_is_mega),
    .lu_access_o            (lu_access),
    .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
    .lsu_dtlb_ppn_o         (lsu_dtlb_ppn_o),
    .dtlb_miss_o            (dtlb_miss_o),
    .req_q_o                (req_q),
    .vaddr_q_o              (vaddr_q),
    .is_store_q_o           (is_store_q),
    .misaligned_q_o         (misaligned_q),
    .translate_q_o          (translate_q),
    .hit_q_o                (hit_q),
    .ppn_q_o                (ppn_q),
    .flags_q_o              (flags_q),
    .mega_q_o               (mega_q),
    .priv_q_o               (priv_q),
    .sum_q_o                (sum_q)
  );

  dtlb_execute u_execute (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lu_access_i      (lu_access),
    .lu_vaddr_i       (lsu_vaddr_i),
    .lu_asid_i        (asid_i),
    .flush_i          (flush_tlb_i),
    .update_valid_i   (update_valid_i),
    .update_vpn_i     (update_vpn_i),
    .update_asid_i    (update_asid_i),
    .update_ppn_i     (update_ppn_i),
    .update_flags_i   (update_flags_i),
    .update_is_mega_i (update_is_mega_i),
    .lu_hit_o         (lu_hit),
    .lu_ppn_o         (lu_ppn),
    .lu_flags_o       (lu_flags),
    .lu_is_mega_o     (lu_is_mega)
  );

  translation_result u_result (
    .req_q_i        (req_q),
    .vaddr_q_i      (vaddr_q),
    .is_store_q_i   (is_store_q),
    .misaligned_q_i (misaligned_q),
    .translate_q_i  (translate_q),
    .hit_q_i        (hit_q),
    .ppn_q_i        (ppn_q),
    .flags_q_i      (flags_q),
    .mega_q_i       (mega_q),
    .priv_q_i       (priv_q),
    .sum_q_i        (sum_q),
    .lsu_valid_o    (lsu_valid_o),
    .lsu_paddr_o    (lsu_paddr_o),
    .lsu_ex_valid_o (lsu_ex_valid_o),
    .lsu_ex_cause_o (lsu_ex_cause_o),
    .lsu_ex_tval_o  (lsu_ex_tval_o)
  );

endmodule

// File: sim/tb_vectors.svh
//--------------------------------------------------------------------
// MMU test table
//--------------------------------------------------------------------
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_ROWS = 23;

// request row: rnd, en, priv, sum, asid, vaddr, store, misaligned
// expected: hit, ppn, miss, valid, paddr, ex valid, cause, tval
// refill row: vpn, asid, ppn, flags, mega
task automatic load_table();
  // bare mode, paddr is the vaddr
  add_request(Y, N, PS, N, 9'h001, 32'h8000_1000, N, N);
  set_expected(Y, 22'h080001, N, Y, 34'h0_8000_1000, N, 4'd0, 32'h0);
  // miss on an empty TLB, then refill a supervisor page
  add_request(Y, Y, PS, N, 9'h001, 32'h0040_2000, N, N);
  set_expected(N, 22'h000000, Y, N, 34'h0, N, 4'd0, 32'h0);
  add_refill(20'h00402, 9'h001, 22'h012345, 8'hc7, N);
  // three requests back to back on the refilled page
  add_request(Y, Y, PS, N, 9'h001, 32'h0040_2000, N, N);
  set_expected(Y, 22'h012345, N, Y, 34'h0_1234_5000, N, 4'd0, 32'h0);
  add_request(Y, Y, PU, N, 9'h001, 32'h0040_2000, N, N);
  set_expected(Y, 22'h012345, N, Y, 34'h0_1234_5000, Y, 4'd13, 32'h0040_2000);
  add_request(Y, Y, PS, N, 9'h001, 32'h0040_2000, Y, N);
  set_expected(Y, 22'h012345, N, Y, 34'h0_1234_5000, N, 4'd0, 32'h0);
  // user megapage, S mode needs SUM
  add_refill(20'h80400, 9'h001, 22'h02ac00, 8'hd7, Y);
  add_request(Y, Y, PS, N, 9'h001, 32'h8053_7000, N, N);
  set_expected(Y, 22'h02ad37, N, Y, 34'h0_2ad3_7000, Y, 4'd13, 32'h8053_7000);
  add_request(Y, Y, PS, Y, 9'h001, 32'h8053_7000, N, N);
  set_expected(Y, 22'h02ad37, N, Y, 34'h0_2ad3_7000, N, 4'd0, 32'h0);
  // W clear page, then a global page with D clear
  add_refill(20'h00500, 9'h001, 22'h000777, 8'hc3, N);
  add_refill(20'h00600, 9'h002, 22'h000888, 8'h67, N);
  add_request(N, Y, PS, N, 9'h001, 32'h0050_0000, Y, N);
  set_expected(Y, 22'h000777, N, Y, 34'h0_0077_7000, Y, 4'd15, 32'h0050_0000);
  add_request(N, Y, PS, N, 9'h001, 32'h0060_0000, Y, N);
  set_expected(Y, 22'h000888, N, Y, 34'h0_0088_8000, Y, 4'd15, 32'h0060_0000);
  // foreign ASID on a non global entry
  add_request(N, Y, PS, N, 9'h003, 32'h0040_2000, N, N);
  set_expected(N, 22'h000000, Y, N, 34'h0, N, 4'd0, 32'h0);
  // fifth refill replaces the oldest entry
  add_refill(20'h00900, 9'h001, 22'h000999, 8'hc7, N);
  add_request(N, Y, PS, N, 9'h001, 32'h0040_2000, N, N);
  set_expected(N, 22'h000000, Y, N, 34'h0, N, 4'd0, 32'h0);
  add_request(Y, Y, PS, N, 9'h001, 32'h0090_0000, N, N);
  set_expected(Y, 22'h000999, N, Y, 34'h0_0099_9000, N, 4'd0, 32'h0);
  add_plain_row(K_FLUSH);
  add_request(N, Y, PS, N, 9'h001, 32'h0090_0000, N, N);
  set_expected(N, 22'h000000, Y, N, 34'h0, N, 4'd0, 32'h0);
  // global entries are flushed too
  add_request(N, Y, PS, N, 9'h005, 32'h0060_0000, N, N);
  set_expected(N, 22'h000000, Y, N, 34'h0, N, 4'd0, 32'h0);
  // misaligned on an empty TLB
  add_request(N, Y, PS, N, 9'h001, 32'h0070_0001, N, Y);
  set_expected(N, 22'h000000, N, Y, 34'h0, Y, 4'd4, 32'h0070_0001);
  add_request(N, Y, PS, N, 9'h001, 32'h0070_0002, Y, Y);
  set_expected(N, 22'h000000, N, Y, 34'h0, Y, 4'd6, 32'h0070_0002);
  add_plain_row(K_IDLE);
endtask

`endif

// File: sim/tb_mmu_top.sv
//--------------------------------------------------------------------
// Data-side MMU testbench
//--------------------------------------------------------------------
`include "mmu_defs.svh"

module tb_mmu_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD  = 100;
  localparam int          DRIVE_DELAY = 5;
  localparam int          CHECK_DELAY = 40;
  localparam int unsigned SEED        = 32'h3d35fa92;

  // row kinds
  localparam logic [1:0] K_IDLE  = 2'd0;
  localparam logic [1:0] K_REQ   = 2'd1;
  localparam logic [1:0] K_FILL  = 2'd2;
  localparam logic [1:0] K_FLUSH = 2'd3;

  localparam logic           Y  = 1'b1;
  localparam logic           N  = 1'b0;
  localparam mmu_pkg::priv_t PU = mmu_pkg::priv_t'(`PRIV_U);
  localparam mmu_pkg::priv_t PS = mmu_pkg::priv_t'(`PRIV_S);

  // refill rows carry the VPN in vaddr bits 31..12
  typedef struct packed {
    logic [1:0]          kind;
    logic                rnd;
    logic                en;
    mmu_pkg::priv_t      priv;
    logic                sum;
    mmu_pkg::asid_t      asid;
    mmu_pkg::vaddr_t     vaddr;
    logic                store;
    logic                mis;
    mmu_pkg::ppn_t       ppn;
    mmu_pkg::pte_flags_t flags;
    logic                mega;
    logic                exp_hit;
    mmu_pkg::ppn_t       exp_ppn;
    logic                exp_miss;
    logic                exp_valid;
    mmu_pkg::paddr_t     exp_paddr;
    logic                exp_exv;
    mmu_pkg::exc_cause_t exp_cause;
    mmu_pkg::vaddr_t     exp_tval;
  } row_t;

  `include "tb_vectors.svh"

  row_t        rows    [NUM_ROWS];
  logic [11:0] row_off [NUM_ROWS];
  int          n_rows = 0;

  logic                clk_i;
  logic                rst_ni;
  logic                en_ld_st_translation_i;
  mmu_pkg::priv_t      ld_st_priv_lvl_i;
  logic                sum_i;
  mmu_pkg::asid_t      asid_i;
  logic                lsu_req_i;
  mmu_pkg::vaddr_t     lsu_vaddr_i;
  logic                lsu_is_store_i;
  logic                misaligned_i;
  logic                update_valid_i;
  mmu_pkg::vpn_t       update_vpn_i;
  mmu_pkg::asid_t      update_asid_i;
  mmu_pkg::ppn_t       update_ppn_i;
  mmu_pkg::pte_flags_t update_flags_i;
  logic                update_is_mega_i;
  logic                flush_tlb_i;
  logic                lsu_dtlb_hit_o;
  mmu_pkg::ppn_t       lsu_dtlb_ppn_o;
  logic                lsu_valid_o;
  mmu_pkg::paddr_t     lsu_paddr_o;
  logic                lsu_ex_valid_o;
  mmu_pkg::exc_cause_t lsu_ex_cause_o;
  mmu_pkg::vaddr_t     lsu_ex_tval_o;
  logic                dtlb_miss_o;

  mmu_top u_mmu_top (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .ld_st_priv_lvl_i       (ld_st_priv_lvl_i),
    .sum_i                  (sum_i),
    .asid_i                 (asid_i),
    .lsu_req_i              (lsu_req_i),
    .lsu_vaddr_i            (lsu_vaddr_i),
    .lsu_is_store_i         (lsu_is_store_i),
    .misaligned_i           (misaligned_i),
    .update_valid_i         (update_valid_i),
    .update_vpn_i           (update_vpn_i),
    .update_asid_i          (update_asid_i),
    .update_ppn_i           (update_ppn_i),
    .update_flags_i         (update_flags_i),
    .update_is_mega_i       (update_is_mega_i),
    .flush_tlb_i            (flush_tlb_i),
    .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
    .lsu_dtlb_ppn_o         (lsu_dtlb_ppn_o),
    .lsu_valid_o            (lsu_valid_o),
    .lsu_paddr_o            (lsu_paddr_o),
    .lsu_ex_valid_o         (lsu_ex_valid_o),
    .lsu_ex_cause_o         (lsu_ex_cause_o),
    .lsu_ex_tval_o          (lsu_ex_tval_o),
    .dtlb_miss_o            (dtlb_miss_o)
  );

  //--------------------------------------------------------------------
  // table building
  //--------------------------------------------------------------------
  task automatic add_request(input logic rnd, input logic en, input mmu_pkg::priv_t priv,
                             input logic sum, input mmu_pkg::asid_t asid,
                             input mmu_pkg::vaddr_t vaddr, input logic store,
                             input logic mis);
    row_t r;
    r       = '0;
    r.kind  = K_REQ;
    r.rnd   = rnd;
    r.en    = en;
    r.priv  = priv;
    r.sum   = sum;
    r.asid  = asid;
    r.vaddr = vaddr;
    r.store = store;
    r.mis   = mis;
    rows[n_rows] = r;
  endtask

  // closes the request row opened by add_request
  task automatic set_expected(input logic hit, input mmu_pkg::ppn_t ppn, input logic miss,
                              input logic valid, input mmu_pkg::paddr_t paddr,
                              input logic exv, input mmu_pkg::exc_cause_t cause,
                              input mmu_pkg::vaddr_t tval);
    rows[n_rows].exp_hit   = hit;
    rows[n_rows].exp_ppn   = ppn;
    rows[n_rows].exp_miss  = miss;
    rows[n_rows].exp_valid = valid;
    rows[n_rows].exp_paddr = paddr;
    rows[n_rows].exp_exv   = exv;
    rows[n_rows].exp_cause = cause;
    rows[n_rows].exp_tval  = tval;
    n_rows++;
  endtask

  task automatic add_refill(input mmu_pkg::vpn_t vpn, input mmu_pkg::asid_t asid,
                            input mmu_pkg::ppn_t ppn, input mmu_pkg::pte_flags_t flags,
                            input logic mega);
    row_t r;
    r       = '0;
    r.kind  = K_FILL;
    r.asid  = asid;
    r.vaddr = {vpn, 12'h000};
    r.ppn   = ppn;
    r.flags = flags;
    r.mega  = mega;
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic add_plain_row(input logic [1:0] kind);
    row_t r;
    r      = '0;
    r.kind = kind;
    rows[n_rows] = r;
    n_rows++;
  endtask

  //--------------------------------------------------------------------
  // failure reporting and compare tasks
  //--------------------------------------------------------------------
  task automatic stop_with_failure();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic fail_plain(input string why);
    $display("%s", why);
    stop_with_failure();
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_ppn(input string name, input mmu_pkg::ppn_t act,
                           input mmu_pkg::ppn_t exp);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_paddr(input string name, input mmu_pkg::paddr_t act,
                             input mmu_pkg::paddr_t exp);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_cause(input string name, input mmu_pkg::exc_cause_t act,
                             input mmu_pkg::exc_cause_t exp);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_vaddr(input string name, input mmu_pkg::vaddr_t act,
                             input mmu_pkg::vaddr_t exp);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  //--------------------------------------------------------------------
  // drive and check one row
  //--------------------------------------------------------------------
  task automatic apply_row(input int i);
    // random page offset, kept for the expected values
    row_off[i]             = rows[i].rnd ? 12'($urandom()) : 12'h000;
    en_ld_st_translation_i = rows[i].en;
    ld_st_priv_lvl_i       = rows[i].priv;
    sum_i                  = rows[i].sum;
    asid_i                 = rows[i].asid;
    lsu_req_i              = (rows[i].kind == K_REQ);
    lsu_vaddr_i            = rows[i].vaddr | {20'h0, row_off[i]};
    lsu_is_store_i         = rows[i].store;
    misaligned_i           = rows[i].mis;
    update_valid_i         = (rows[i].kind == K_FILL);
    update_vpn_i           = rows[i].vaddr[31:12];
    update_asid_i          = rows[i].asid;
    update_ppn_i           = rows[i].ppn;
    update_flags_i         = rows[i].flags;
    update_is_mega_i       = rows[i].mega;
    flush_tlb_i            = (rows[i].kind == K_FLUSH);
  endtask

  // cycle 0, combinational answer to the current row
  task automatic check_lookup(input int i);
    check_bit("dtlb_miss_o", dtlb_miss_o, rows[i].exp_miss);
    if (rows[i].kind == K_REQ) begin
      check_bit("lsu_dtlb_hit_o", lsu_dtlb_hit_o, rows[i].exp_hit);
      if (rows[i].exp_hit) begin
        check_ppn("lsu_dtlb_ppn_o", lsu_dtlb_ppn_o, rows[i].exp_ppn);
      end
    end
  endtask

  // cycle 1, registered result of an earlier row
  task automatic check_result(input int i);
    mmu_pkg::vaddr_t tval;
    tval = rows[i].exp_exv ? (rows[i].exp_tval | {20'h0, row_off[i]}) : '0;
    check_bit("lsu_valid_o", lsu_valid_o, rows[i].exp_valid);
    check_bit("lsu_ex_valid_o", lsu_ex_valid_o, rows[i].exp_exv);
    // misaligned requests carry no translated address
    if (rows[i].exp_valid && !rows[i].mis) begin
      check_paddr("lsu_paddr_o", lsu_paddr_o, rows[i].exp_paddr | {22'h0, row_off[i]});
    end
    if (rows[i].exp_exv) begin
      check_cause("lsu_ex_cause_o", lsu_ex_cause_o, rows[i].exp_cause);
    end
    check_vaddr("lsu_ex_tval_o", lsu_ex_tval_o, tval);
  endtask

  //--------------------------------------------------------------------
  // clock, watchdog and main sequence
  //--------------------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #((NUM_ROWS + 10) * CLK_PERIOD);
    $display("watchdog expired before the test table was finished");
    stop_with_failure();
  end

  initial begin
    void'($urandom(SEED));
    rst_ni                 = 1'b0;
    en_ld_st_translation_i = 1'b0;
    ld_st_priv_lvl_i       = PS;
    sum_i                  = 1'b0;
    asid_i                 = '0;
    lsu_req_i              = 1'b0;
    lsu_vaddr_i            = '0;
    lsu_is_store_i         = 1'b0;
    misaligned_i           = 1'b0;
    update_valid_i         = 1'b0;
    update_vpn_i           = '0;
    update_asid_i          = '0;
    update_ppn_i           = '0;
    update_flags_i         = '0;
    update_is_mega_i       = 1'b0;
    flush_tlb_i            = 1'b0;
    load_table();
    if (n_rows != NUM_ROWS) begin
      fail_plain("test table row count does not match its declared length");
    end
    repeat (3) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      apply_row(i);
      #CHECK_DELAY;
      check_lookup(i);
      if (i > 0) begin
        check_result(i - 1);
      end
    end
    @(posedge clk_i);
    #(DRIVE_DELAY + CHECK_DELAY);
    check_result(NUM_ROWS - 1);
    $display("Test OK");
    $finish;
  end

endmodule

// File: project.f
+incdir+logic
+incdir+sim
logic/mmu_pkg.sv
logic/lsu_req_decode.sv
logic/dtlb_execute.sv
logic/translation_result.sv
logic/mmu_top.sv
sim/tb_mmu_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the MMU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_mmu_top -Mdir obj_dir \
  || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_mmu_top 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -q "Test OK" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
